/* build.f */
rtl/dispatch_pkg.sv
rtl/sync_fifo.sv
rtl/rename.sv
rtl/rename_table.sv
rtl/dispatch.sv
rtl/dispatch_top.sv
tb/tb_dispatch.sv

/* rtl/dispatch.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dispatch of the instruction queue head. Renames it, picks the issue
// unit, and pushes it to that unit and to the reorder queue in the same
// cycle. Fences take no unit and wait for the memory sides to drain.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dispatch import dispatch_pkg::*; (
	input micro_instr_t iq_head,
	input logic iq_empty,
	output logic iq_pop,
	input logic rob_full,
	output logic rob_push,
	output rob_entry_t rob_info,
	input unit_vec_t issue_full,
	output unit_vec_t issue_push,
	output issue_pkt_t issue_info,
	input logic su_empty,
	input logic lu_busy,
	output logic alloc,
	output phy_tag_t alloc_tag,
	input logic [ARCH_REGS-1:0][SLOT_W-1:0] active_slots,
	input logic [ARCH_REGS-1:0][RB-1:0] used_masks
);

	unit_e tgt_unit;
	logic rd_valid;
	logic is_fence;
	logic is_fence_i;
	phy_tag_t rs1_tag;
	phy_tag_t rs2_tag;
	phy_tag_t rd_tag;
	phy_tag_t rd_out;
	logic rd_run_out;
	fence_set_t pred;
	fence_set_t succ;
	logic wait_ld;
	logic wait_st;
	logic after_ld;
	logic after_st;
	logic fence_stall;
	logic unit_ready;
	logic dispatch_go;

	always_comb begin
		tgt_unit = unit_adder;
		rd_valid = 1'b1;
		is_fence = 1'b0;
		is_fence_i = 1'b0;
		case (iq_head.op)
			op_slti, op_sltiu, op_slt, op_sltu, op_xori, op_ori, op_andi,
			op_xor, op_or, op_and: tgt_unit = unit_logcmp;
			op_slli, op_slliw, op_sll, op_sllw, op_srli, op_srliw, op_srl, op_srlw,
			op_srai, op_sraiw, op_sra, op_sraw: tgt_unit = unit_shift;
			op_jal, op_jalr: tgt_unit = unit_jal;
			op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
				tgt_unit = unit_bru;
				rd_valid = 1'b0;
			end
			op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu: tgt_unit = unit_lu;
			op_sb, op_sh, op_sw, op_sd: begin
				tgt_unit = unit_su;
				rd_valid = 1'b0;
			end
			op_fence: begin
				is_fence = 1'b1;
				rd_valid = 1'b0;
			end
			op_fence_i: begin
				is_fence_i = 1'b1;
				rd_valid = 1'b0;
			end
			op_csrrw, op_csrrs, op_csrrc, op_csrrwi, op_csrrsi, op_csrrci: tgt_unit = unit_csr;
			default: tgt_unit = unit_adder;
		endcase
	end

	// r and i order the load side, w and o the store side
	assign pred = iq_head.imm.fence.pred;
	assign succ = iq_head.imm.fence.succ;
	assign wait_ld = succ.r | succ.i;
	assign wait_st = succ.w | succ.o;
	assign after_ld = pred.r | pred.i;
	assign after_st = pred.w | pred.o;

	assign fence_stall = (is_fence & (wait_ld | wait_st)
			& ((after_st & ~su_empty) | (after_ld & lu_busy)))
		| (is_fence_i & (~su_empty | lu_busy));

	assign unit_ready = (is_fence | is_fence_i) ? ~fence_stall : ~issue_full[tgt_unit];
	assign dispatch_go = ~iq_empty & ~rob_full & ~rd_run_out & unit_ready;

	assign issue_push = (dispatch_go & ~is_fence & ~is_fence_i)
		? unit_vec_t'(1) << tgt_unit : '0;
	assign rob_push = dispatch_go;
	assign iq_pop = dispatch_go;
	assign alloc = dispatch_go & rd_valid;
	assign alloc_tag = rd_tag;

	// instructions without a destination carry a zero rd tag
	assign rd_out = rd_valid ? rd_tag : '0;

	assign issue_info = '{
		op: iq_head.op,
		pc: iq_head.pc,
		imm: iq_head.imm,
		rd: rd_out,
		rs1: rs1_tag,
		rs2: rs2_tag,
		is_rvc: iq_head.is_rvc
	};

	// fences keep the adder default, so none of the flags is set for them
	assign rob_info = '{
		pc: iq_head.pc,
		rd: rd_out,
		rd_valid: rd_valid,
		is_branch: (tgt_unit == unit_bru),
		is_su: (tgt_unit == unit_su),
		is_csr: (tgt_unit == unit_csr)
	};

	rename i_rename (
		.active_slots(active_slots),
		.used_masks(used_masks),
		.rs1_raw(iq_head.rs1),
		.rs2_raw(iq_head.rs2),
		.rd_raw(iq_head.rd),
		.rd_valid(rd_valid),
		.rs1_tag(rs1_tag),
		.rs2_tag(rs2_tag),
		.rd_tag(rd_tag),
		.rd_run_out(rd_run_out)
	);

endmodule

/* rtl/dispatch_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared sizes and types for the dispatch stage of the RV64I core.
// Every RTL module and the testbench import this package.
// Holds the op and unit encodings, the immediate view and the
// packet formats that move between the queues and dispatch.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package dispatch_pkg;

	localparam int ARCH_REGS = 32;
	localparam int RB = 4;
	localparam int SLOT_W = 2;
	localparam int NUM_UNITS = 8;
	localparam int IQ_DEPTH = 4;
	localparam int ROB_DEPTH = 8;

	typedef enum logic [5:0] {
		op_lui, op_auipc, op_addi, op_addiw, op_add, op_addw, op_sub, op_subw,
		op_slti, op_sltiu, op_slt, op_sltu, op_xori, op_ori, op_andi,
		op_xor, op_or, op_and,
		op_slli, op_slliw, op_sll, op_sllw, op_srli, op_srliw, op_srl, op_srlw,
		op_srai, op_sraiw, op_sra, op_sraw,
		op_jal, op_jalr,
		op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
		op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
		op_sb, op_sh, op_sw, op_sd,
		op_fence, op_fence_i,
		op_csrrw, op_csrrs, op_csrrc, op_csrrwi, op_csrrsi, op_csrrci
	} rv_op_e;

	// bit position in unit_vec_t follows this order
	typedef enum logic [2:0] {
		unit_adder,
		unit_logcmp,
		unit_shift,
		unit_jal,
		unit_bru,
		unit_su,
		unit_lu,
		unit_csr
	} unit_e;

	typedef logic [NUM_UNITS-1:0] unit_vec_t;

	typedef struct packed {
		logic [4:0] arch;
		logic [SLOT_W-1:0] slot;
	} phy_tag_t;

	typedef struct packed {
		logic i;
		logic o;
		logic r;
		logic w;
	} fence_set_t;

	typedef struct packed {
		logic [55:0] rsvd;
		fence_set_t pred;
		fence_set_t succ;
	} fence_imm_t;

	// a fence carries its ordering sets in the low byte of the immediate
	typedef union packed {
		logic [63:0] word;
		fence_imm_t fence;
	} imm_u;

	typedef struct packed {
		rv_op_e op;
		logic [63:0] pc;
		imm_u imm;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic is_rvc;
	} micro_instr_t;

	typedef struct packed {
		rv_op_e op;
		logic [63:0] pc;
		imm_u imm;
		phy_tag_t rd;
		phy_tag_t rs1;
		phy_tag_t rs2;
		logic is_rvc;
	} issue_pkt_t;

	typedef struct packed {
		logic [63:0] pc;
		phy_tag_t rd;
		logic rd_valid;
		logic is_branch;
		logic is_su;
		logic is_csr;
	} rob_entry_t;

endpackage

/* rtl/dispatch_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dispatch subsystem top. The front end fills the instruction queue,
// dispatch renames and routes the head, and commit drains the reorder
// queue and returns physical copies through the free port.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dispatch_top import dispatch_pkg::*; (
	input logic CLK,
	input logic rst,
	input logic fe_push,
	input micro_instr_t fe_instr,
	output logic fe_full,
	output unit_vec_t issue_push,
	input unit_vec_t issue_full,
	output issue_pkt_t issue_info,
	input logic su_empty,
	input logic lu_busy,
	input logic rob_pop,
	output rob_entry_t rob_head,
	output logic rob_empty,
	input logic free_valid,
	input phy_tag_t free_tag
);

	micro_instr_t iq_head;
	logic iq_empty;
	logic iq_pop;
	logic rob_full;
	logic rob_push;
	rob_entry_t rob_info;
	logic alloc;
	phy_tag_t alloc_tag;
	logic [ARCH_REGS-1:0][SLOT_W-1:0] active_slots;
	logic [ARCH_REGS-1:0][RB-1:0] used_masks;

	sync_fifo #(
		.DEPTH(IQ_DEPTH),
		.entry_t(micro_instr_t)
	) i_instr_fifo (
		.CLK(CLK),
		.rst(rst),
		.push(fe_push),
		.din(fe_instr),
		.pop(iq_pop),
		.dout(iq_head),
		.full(fe_full),
		.empty(iq_empty)
	);

	dispatch i_dispatch (
		.iq_head(iq_head),
		.iq_empty(iq_empty),
		.iq_pop(iq_pop),
		.rob_full(rob_full),
		.rob_push(rob_push),
		.rob_info(rob_info),
		.issue_full(issue_full),
		.issue_push(issue_push),
		.issue_info(issue_info),
		.su_empty(su_empty),
		.lu_busy(lu_busy),
		.alloc(alloc),
		.alloc_tag(alloc_tag),
		.active_slots(active_slots),
		.used_masks(used_masks)
	);

	rename_table i_rename_table (
		.CLK(CLK),
		.rst(rst),
		.alloc(alloc),
		.alloc_tag(alloc_tag),
		.free_valid(free_valid),
		.free_tag(free_tag),
		.active_slots(active_slots),
		.used_masks(used_masks)
	);

	// in-order record for commit
	sync_fifo #(
		.DEPTH(ROB_DEPTH),
		.entry_t(rob_entry_t)
	) i_rob_fifo (
		.CLK(CLK),
		.rst(rst),
		.push(rob_push),
		.din(rob_info),
		.pop(rob_pop),
		.dout(rob_head),
		.full(rob_full),
		.empty(rob_empty)
	);

endmodule

/* rtl/rename.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational rename lookup used by dispatch.
// Sources map to their active copy; the destination takes the lowest
// free copy, and rd_run_out flags a destination with none left.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rename import dispatch_pkg::*; (
	input logic [ARCH_REGS-1:0][SLOT_W-1:0] active_slots,
	input logic [ARCH_REGS-1:0][RB-1:0] used_masks,
	input logic [4:0] rs1_raw,
	input logic [4:0] rs2_raw,
	input logic [4:0] rd_raw,
	input logic rd_valid,
	output phy_tag_t rs1_tag,
	output phy_tag_t rs2_tag,
	output phy_tag_t rd_tag,
	output logic rd_run_out
);

	logic [RB-1:0] rd_mask;
	logic [SLOT_W-1:0] free_slot;

	assign rs1_tag = '{arch: rs1_raw, slot: active_slots[rs1_raw]};
	assign rs2_tag = '{arch: rs2_raw, slot: active_slots[rs2_raw]};

	assign rd_mask = used_masks[rd_raw];

	// scan from the top so the lowest free slot is the one left standing
	always_comb begin
		free_slot = '0;
		for (int i = RB - 1; i >= 0; i--) begin
			if (!rd_mask[i])
				free_slot = SLOT_W'(i);
		end
	end

	assign rd_tag = '{arch: rd_raw, slot: free_slot};

	// all copies busy, the writer has to wait for a release
	assign rd_run_out = rd_valid & (&rd_mask);

endmodule

/* rtl/rename_table.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename state: the active physical copy and the in-use mask of each
// architectural register. Dispatch allocates a copy through alloc,
// commit hands one back through the free port.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rename_table import dispatch_pkg::*; (
	input logic CLK,
	input logic rst,
	input logic alloc,
	input phy_tag_t alloc_tag,
	input logic free_valid,
	input phy_tag_t free_tag,
	output logic [ARCH_REGS-1:0][SLOT_W-1:0] active_slots,
	output logic [ARCH_REGS-1:0][RB-1:0] used_masks
);

	logic [ARCH_REGS-1:0][SLOT_W-1:0] active_nxt;
	logic [ARCH_REGS-1:0][RB-1:0] used_nxt;

	always_comb begin
		active_nxt = active_slots;
		used_nxt = used_masks;
		if (free_valid)
			used_nxt[free_tag.arch][free_tag.slot] = 1'b0;
		// allocation comes last so it wins over a release of the same slot
		if (alloc) begin
			used_nxt[alloc_tag.arch][alloc_tag.slot] = 1'b1;
			active_nxt[alloc_tag.arch] = alloc_tag.slot;
		end
	end

	// out of reset every register lives in slot 0
	always_ff @(posedge CLK) begin
		if (rst) begin
			active_slots <= '0;
			used_masks <= {ARCH_REGS{RB'(1)}};
		end else begin
			active_slots <= active_nxt;
			used_masks <= used_nxt;
		end
	end

endmodule

/* rtl/sync_fifo.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous first-word-fall-through queue of any packed entry type.
// The head stays on dout until it is popped. Full and empty are
// registered; a push while full or a pop while empty is dropped.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sync_fifo #(
	parameter int DEPTH = 4,
	parameter type entry_t = logic [7:0]
) (
	input logic CLK,
	input logic rst,
	input logic push,
	input entry_t din,
	input logic pop,
	output entry_t dout,
	output logic full,
	output logic empty
);

	entry_t mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic [$clog2(DEPTH+1)-1:0] count_nxt;
	logic do_push;
	logic do_pop;

	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	// push and pop together leave the count alone
	always_comb begin
		count_nxt = count;
		if (do_push & ~do_pop)
			count_nxt = count + 1'b1;
		else if (do_pop & ~do_push)
			count_nxt = count - 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			full <= 1'b0;
			empty <= 1'b1;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			count <= count_nxt;
			full <= (count_nxt == DEPTH);
			empty <= (count_nxt == 0);
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	assign dout = mem[rd_ptr];

endmodule

/* run.sh */
#!/bin/sh
# builds the dispatch testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_dispatch -o tb_dispatch &&
./obj_dir/tb_dispatch | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "dispatch run passed" ||
{ echo "dispatch run failed"; exit 1; }

/* tb/dispatch_stimulus.txt */
# all fields hex; a tag is arch*4+slot; unit 8 means no issue push (fences)
# T name | I op pc imm rd rs1 rs2 unit exp_rd exp_rs1 exp_rs2 rd_valid branch store csr
# F issue_full su_empty lu_busy | R tag | W cycles | N issued_in_test rob_empty | P pops
T unit_classes
I 04 1000 0 01 02 03 0 05 08 0c 1 0 0 0
I 0f 1004 0 04 05 06 1 11 14 18 1 0 0 0
I 14 1008 0 07 08 09 2 1d 20 24 1 0 0 0
I 1e 100c 40 0a 00 00 3 29 00 00 1 0 0 0
I 20 1010 ffffffffffffffe0 00 0b 0c 4 00 2c 30 0 1 0 0
I 30 1014 8 00 0d 0e 5 00 34 38 0 0 1 0
I 29 1018 10 0f 10 00 6 3d 40 00 1 0 0 0
I 33 101c 300 11 12 00 7 45 48 00 1 0 0 1
P 8
T rename_slots
I 02 2000 1 14 00 00 0 51 00 00 1 0 0 0
I 02 2004 2 14 14 00 0 52 51 00 1 0 0 0
I 02 2008 3 14 14 00 0 53 52 00 1 0 0 0
I 04 200c 0 15 14 14 0 55 53 53 1 0 0 0
P 4
I 02 2010 4 14 14 00 0 52 53 00 1 0 0 0
W 8
N 4 1
R 52
P 1
T unit_full
F 04 1 0
I 14 3000 0 16 18 19 2 59 60 64 1 0 0 0
I 04 3004 0 17 18 19 0 5d 60 64 1 0 0 0
W 8
N 0 1
F 00 1 0
P 2
T rob_fill
I 30 4000 0 00 1c 1d 5 00 70 74 0 0 1 0
I 30 4004 8 00 1c 1d 5 00 70 74 0 0 1 0
I 30 4008 10 00 1e 1f 5 00 78 7c 0 0 1 0
I 30 400c 18 00 1e 1f 5 00 78 7c 0 0 1 0
I 20 4010 20 00 1c 1e 4 00 70 78 0 1 0 0
I 21 4014 24 00 1d 1f 4 00 74 7c 0 1 0 0
I 22 4018 28 00 1c 1f 4 00 70 7c 0 1 0 0
I 31 401c 33 00 00 00 8 00 00 00 0 0 0 0
I 33 4020 305 1b 1c 00 7 6d 70 00 1 0 0 1
W 8
N 7 0
P 9
T fence_stall
F 00 0 0
I 31 5000 12 00 00 00 8 00 00 00 0 0 0 0
W 8
N 0 1
F 00 1 0
P 1
F 00 1 1
I 32 5004 0 00 00 00 8 00 00 00 0 0 0 0
W 8
N 0 1
F 00 1 0
P 1
F 00 0 0
I 31 5008 21 00 00 00 8 00 00 00 0 0 0 0
P 1
F 00 1 0

/* tb/tb_dispatch.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for the dispatch subsystem top level.
// Runs the command lines of the stimulus file: pushes instructions,
// sets back-pressure, releases tags and pops the reorder queue, and
// checks every issue packet and reorder entry against the file.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_dispatch import dispatch_pkg::*; ();

	logic CLK;
	logic rst;
	logic fe_push;
	micro_instr_t fe_instr;
	logic fe_full;
	unit_vec_t issue_push;
	unit_vec_t issue_full;
	issue_pkt_t issue_info;
	logic su_empty;
	logic lu_busy;
	logic rob_pop;
	rob_entry_t rob_head;
	logic rob_empty;
	logic free_valid;
	phy_tag_t free_tag;

	string cmds[$];
	issue_pkt_t exp_pkts[$];
	unit_vec_t exp_units[$];
	rob_entry_t exp_robs[$];
	string test_name = "";
	bit test_open = 1'b0;
	bit loaded = 1'b0;
	logic rvc_flag = 1'b0;
	int issued_in_test = 0;
	int test_errors = 0;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;

	dispatch_top DUT (.*);

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;

	task automatic count_error();
		errors++;
		test_errors++;
	endtask

	task automatic check_issue(issue_pkt_t exp_pkt, unit_vec_t exp_unit,
			issue_pkt_t act_pkt, unit_vec_t act_unit);
		checks++;
		if (act_unit !== exp_unit) begin
			$display("ERR %s issue unit: expected %b actual %b", test_name, exp_unit, act_unit);
			count_error();
		end
		if (act_pkt !== exp_pkt) begin
			$display("ERR %s issue packet: expected %h actual %h", test_name, exp_pkt, act_pkt);
			count_error();
		end
	endtask

	task automatic check_rob(rob_entry_t exp_ent, rob_entry_t act_ent);
		checks++;
		if (act_ent !== exp_ent) begin
			$display("ERR %s rob entry: expected %h actual %h", test_name, exp_ent, act_ent);
			count_error();
		end
	endtask

	task automatic check_stall(int exp_issued, logic exp_rob_empty);
		checks++;
		if (issued_in_test != exp_issued) begin
			$display("ERR %s issue count: expected %0d actual %0d", test_name, exp_issued,
				issued_in_test);
			count_error();
		end
		if (rob_empty !== exp_rob_empty) begin
			$display("ERR %s rob_empty: expected %b actual %b", test_name, exp_rob_empty,
				rob_empty);
			count_error();
		end
	endtask

	// every issue push is matched in order against the instructions pushed so far
	always @(posedge CLK) begin
		if (!rst && issue_push != '0) begin
			issued_in_test++;
			if (exp_pkts.size() == 0) begin
				$display("issue push to units %b in test %s with no instruction waiting for it",
					issue_push, test_name);
				count_error();
			end else
				check_issue(exp_pkts.pop_front(), exp_units.pop_front(), issue_info, issue_push);
		end
	end

	task automatic load_commands();
		int fd;
		string line;
		fd = $fopen("tb/dispatch_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file tb/dispatch_stimulus.txt");
			count_error();
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != "#")
					cmds.push_back(line);
			end
			$fclose(fd);
		end
		loaded = 1'b1;
	endtask

	task automatic push_instr(string line);
		logic [63:0] op;
		logic [63:0] pc;
		logic [63:0] imm;
		logic [63:0] rd;
		logic [63:0] rs1;
		logic [63:0] rs2;
		logic [63:0] unit;
		logic [63:0] erd;
		logic [63:0] ers1;
		logic [63:0] ers2;
		logic [63:0] rv;
		logic [63:0] br;
		logic [63:0] su;
		logic [63:0] csr;
		int n;
		micro_instr_t instr;
		issue_pkt_t exp_pkt;
		rob_entry_t exp_rob;
		n = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
			op, pc, imm, rd, rs1, rs2, unit, erd, ers1, ers2, rv, br, su, csr);
		if (n != 14) begin
			$display("instruction line in test %s has %0d fields instead of 14", test_name, n);
			count_error();
		end else begin
			instr = '{op: rv_op_e'(op[5:0]), pc: pc, imm: imm, rd: rd[4:0], rs1: rs1[4:0],
				rs2: rs2[4:0], is_rvc: rvc_flag};
			while (fe_full)
				@(negedge CLK);
			fe_instr = instr;
			fe_push = 1'b1;
			// fences go to no unit but still take a reorder entry
			if (unit < NUM_UNITS) begin
				exp_pkt = '{op: instr.op, pc: pc, imm: imm, rd: phy_tag_t'(erd[6:0]),
					rs1: phy_tag_t'(ers1[6:0]), rs2: phy_tag_t'(ers2[6:0]), is_rvc: rvc_flag};
				exp_pkts.push_back(exp_pkt);
				exp_units.push_back(unit_vec_t'(1) << unit[2:0]);
			end
			exp_rob = '{pc: pc, rd: phy_tag_t'(erd[6:0]), rd_valid: rv[0],
				is_branch: br[0], is_su: su[0], is_csr: csr[0]};
			exp_robs.push_back(exp_rob);
			// the compressed flag alternates from one instruction to the next
			rvc_flag = ~rvc_flag;
			@(negedge CLK);
			fe_push = 1'b0;
		end
	endtask

	task automatic return_tag(phy_tag_t tag);
		@(negedge CLK);
		free_valid = 1'b1;
		free_tag = tag;
		@(negedge CLK);
		free_valid = 1'b0;
	endtask

	task automatic pop_rob(int count);
		for (int i = 0; i < count; i++) begin
			while (rob_empty)
				@(negedge CLK);
			if (exp_robs.size() == 0) begin
				$display("reorder queue holds an entry that no pushed instruction accounts for");
				count_error();
			end else
				check_rob(exp_robs.pop_front(), rob_head);
			rob_pop = 1'b1;
			@(negedge CLK);
			rob_pop = 1'b0;
		end
	endtask

	task automatic finish_test();
		while (exp_pkts.size() != 0)
			@(negedge CLK);
		if (exp_robs.size() != 0) begin
			$display("test %s left %0d reorder entries unchecked", test_name, exp_robs.size());
			count_error();
			exp_robs.delete();
		end
		tests_run++;
		if (test_errors == 0)
			$display("test %s: ok", test_name);
		else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, test_errors);
		end
	endtask

	task automatic run_command(string line);
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] c;
		int n;
		case (line.getc(0))
			"T": begin
				if (test_open)
					finish_test();
				n = $sscanf(line, "T %s", test_name);
				test_open = 1'b1;
				test_errors = 0;
				issued_in_test = 0;
			end
			"I": push_instr(line);
			"F": begin
				n = $sscanf(line, "F %h %h %h", a, b, c);
				@(negedge CLK);
				issue_full = unit_vec_t'(a[7:0]);
				su_empty = b[0];
				lu_busy = c[0];
			end
			"R": begin
				n = $sscanf(line, "R %h", a);
				return_tag(phy_tag_t'(a[6:0]));
			end
			"W": begin
				n = $sscanf(line, "W %h", a);
				repeat (int'(a))
					@(negedge CLK);
			end
			"N": begin
				n = $sscanf(line, "N %h %h", a, b);
				check_stall(int'(a), b[0]);
			end
			"P": begin
				n = $sscanf(line, "P %h", a);
				pop_rob(int'(a));
			end
			default: begin
				$display("unknown command line in the stimulus file: %s", line);
				count_error();
			end
		endcase
	endtask

	// 40 clock cycles of budget for every command line
	initial begin
		wait (loaded);
		repeat ((cmds.size() + 1) * 40)
			@(posedge CLK);
		$display("timeout: the stimulus did not finish within %0d cycles",
			(cmds.size() + 1) * 40);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		rst = 1'b1;
		fe_push = 1'b0;
		fe_instr = '0;
		issue_full = '0;
		su_empty = 1'b1;
		lu_busy = 1'b0;
		rob_pop = 1'b0;
		free_valid = 1'b0;
		free_tag = '0;
		load_commands();
		repeat (16)
			@(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;
		foreach (cmds[i])
			run_command(cmds[i]);
		if (test_open)
			finish_test();
		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
			checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
